//--- design/rot_map_pkg.sv
package rot_map_pkg;

	// bus geometry
	localparam int DATA_W = 32;
	localparam int ADDR_W = 8;

	// register map, byte addresses
	localparam logic [ADDR_W-1:0] ADDR_OP     = 8'h00; // operation register
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 8'h04;
	localparam logic [ADDR_W-1:0] ADDR_UNLOCK = 8'h08; // write only
	localparam logic [ADDR_W-1:0] ADDR_KEY0   = 8'h10; // key bits 31:0
	localparam logic [ADDR_W-1:0] ADDR_KEY1   = 8'h14;
	localparam logic [ADDR_W-1:0] ADDR_KEY2   = 8'h18;
	localparam logic [ADDR_W-1:0] ADDR_KEY3   = 8'h1C; // key bits 127:96
	localparam logic [ADDR_W-1:0] ADDR_TRNG   = 8'h20; // random word

	// opcodes, low byte of a write to ADDR_OP
	typedef enum logic [7:0] {
		OP_NOP          = 8'd0,
		OP_UNLOCK       = 8'd1, // arms the unlock word
		OP_STATUS_CLEAR = 8'd2,
		OP_KEY_CLEAR    = 8'd3,
		OP_TRNG_GEN     = 8'd4,
		OP_TRNG_CLEAR   = 8'd5
	} op_e;

endpackage

//--- design/rot_regs_pkg.sv
package rot_regs_pkg;

	// generation counter width
	localparam int CNT_W = 3;

	// status bits at and below this one are cleared by OP_STATUS_CLEAR
	localparam int CLEARABLE_MSB = 25;

	// status word, msb first
	typedef struct packed {
		logic             check_busy;  // 31
		logic             unlocked;    // 30
		logic             trng_valid;  // 29
		logic [CNT_W-1:0] trng_count;  // 28:26
		logic [19:0]      rsvd_hi;     // 25:6
		logic             key_loaded;  // 5
		logic [3:0]       rsvd_lo;     // 4:1
		logic             root_active; // 0
	} status_fields_t;

	// raw view for the read path and bulk clear, field view for updates
	typedef union packed {
		logic [31:0]    raw;
		status_fields_t f;
	} status_u;

endpackage

//--- design/unlock_checker.sv
module unlock_checker #(
	parameter logic [31:0] UNLOCK_SEQ = 32'hF0F0AAAA
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        unlock_start_i,
	input  logic [31:0] unlock_word_i,
	output logic        check_busy_o,
	output logic        unlock_o
);

	logic [31:0] word_q;   // captured unlock word
	logic [4:0]  idx_q;    // bit under test
	logic        match_q;  // no mismatch so far
	logic        busy_q;
	logic        unlock_q;
	logic        bit_ok;
	logic        match_n;

	assign bit_ok  = (word_q[idx_q] == UNLOCK_SEQ[idx_q]);
	assign match_n = match_q & bit_ok;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q    <= '0;
			match_q  <= 1'b0;
			busy_q   <= 1'b0;
			unlock_q <= 1'b0;
		end else if (busy_q) begin
			// all 32 bits are always walked, pass or fail
			if (idx_q == 5'd0) begin
				busy_q   <= 1'b0;
				unlock_q <= unlock_q | match_n; // sticky until reset
			end else begin
				idx_q <= idx_q - 5'd1;
			end
			match_q <= match_n;
		end else if (unlock_start_i) begin
			idx_q   <= 5'd31; // msb first
			match_q <= 1'b1;
			busy_q  <= 1'b1;
		end
	end

	// word is payload, only sampled on the start pulse
	always_ff @(posedge clk) begin
		if (unlock_start_i && !busy_q) begin
			word_q <= unlock_word_i;
		end
	end

	assign check_busy_o = busy_q;
	assign unlock_o     = unlock_q;

endmodule

//--- design/trng_lfsr.sv
module trng_lfsr #(
	parameter logic [31:0] LFSR_SEED    = 32'hACE1ACE1,
	parameter int          TRNG_MAX_GEN = 6
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           gen_i,
	input  logic                           clr_i,
	output logic [31:0]                    rnd_o,
	output logic                           rnd_valid_o,
	output logic [rot_regs_pkg::CNT_W-1:0] gen_count_o
);

	localparam logic [31:0] TAPS = 32'h80200003; // x^32+x^22+x^2+x+1, right shifting

	logic [31:0]                    lfsr_q;
	logic [31:0]                    lfsr_n;
	logic [31:0]                    rnd_q;
	logic                           valid_q;
	logic [rot_regs_pkg::CNT_W-1:0] cnt_q;
	logic                           accept;

	// 32 galois steps folded into one cycle
	function automatic logic [31:0] step32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		for (int i = 0; i < 32; i++) begin
			v = {1'b0, v[31:1]} ^ (v[0] ? TAPS : 32'h0);
		end
		return v;
	endfunction

	assign lfsr_n = step32(lfsr_q);
	assign accept = gen_i && (cnt_q != rot_regs_pkg::CNT_W'(TRNG_MAX_GEN)); // saturate

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr_q  <= LFSR_SEED;
			rnd_q   <= '0;
			valid_q <= 1'b0;
			cnt_q   <= '0;
		end else if (accept) begin
			lfsr_q  <= lfsr_n;
			rnd_q   <= lfsr_n;
			valid_q <= 1'b1;
			cnt_q   <= cnt_q + 1'b1;
		end else if (clr_i) begin
			rnd_q   <= '0; // count is kept
			valid_q <= 1'b0;
		end
	end

	assign rnd_o       = rnd_q;
	assign rnd_valid_o = valid_q;
	assign gen_count_o = cnt_q;

endmodule

//--- design/rot_regs.sv
module rot_regs (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           we_i,
	input  logic                           re_i,
	input  logic [rot_map_pkg::ADDR_W-1:0] addr_i,
	input  logic [rot_map_pkg::DATA_W-1:0] wdata_i,
	output logic [rot_map_pkg::DATA_W-1:0] rdata_o,
	output logic                           unlock_start_o,
	output logic [rot_map_pkg::DATA_W-1:0] unlock_word_o,
	input  logic                           check_busy_i,
	input  logic                           unlock_i,
	output logic                           trng_gen_o,
	output logic                           trng_clr_o,
	input  logic [rot_map_pkg::DATA_W-1:0] rnd_i,
	input  logic                           rnd_valid_i,
	input  logic [rot_regs_pkg::CNT_W-1:0] gen_count_i
);

	rot_map_pkg::op_e               op;
	logic                           op_wr;
	logic                           idle;
	logic                           access;     // unlocked and no check running
	logic                           arm_op;
	logic                           stat_clr;
	logic                           key_clr;
	logic                           key_hit;
	logic                           key_wr;
	logic [1:0]                     key_idx;
	logic                           armed_q;
	logic                           unlock_q;
	logic                           unlock_rise;
	rot_regs_pkg::status_u          own_q;      // bits owned here
	rot_regs_pkg::status_u          status;
	logic [rot_map_pkg::DATA_W-1:0] key_q [4];
	logic [rot_map_pkg::DATA_W-1:0] rd_mux;
	logic [rot_map_pkg::DATA_W-1:0] rdata_q;

	assign op     = rot_map_pkg::op_e'(wdata_i[7:0]);
	assign op_wr  = we_i && (addr_i == rot_map_pkg::ADDR_OP);
	assign idle   = !check_busy_i;
	assign access = unlock_i && idle;

	assign key_hit = addr_i inside {rot_map_pkg::ADDR_KEY0, rot_map_pkg::ADDR_KEY1,
		rot_map_pkg::ADDR_KEY2, rot_map_pkg::ADDR_KEY3};
	assign key_idx = addr_i[3:2];
	assign key_wr  = we_i && key_hit && access;

	assign unlock_rise = unlock_i && !unlock_q;

	// unlock word only goes through once armed
	assign unlock_start_o = we_i && (addr_i == rot_map_pkg::ADDR_UNLOCK) && armed_q &&
		!unlock_i && idle;
	assign unlock_word_o  = wdata_i;

	always_comb begin
		arm_op     = 1'b0;
		stat_clr   = 1'b0;
		key_clr    = 1'b0;
		trng_gen_o = 1'b0;
		trng_clr_o = 1'b0;
		if (op_wr) begin
			case (op)
				rot_map_pkg::OP_NOP: begin
				end
				rot_map_pkg::OP_UNLOCK:       arm_op     = !unlock_i && idle;
				rot_map_pkg::OP_STATUS_CLEAR: stat_clr   = access;
				rot_map_pkg::OP_KEY_CLEAR:    key_clr    = access;
				rot_map_pkg::OP_TRNG_GEN:     trng_gen_o = access;
				rot_map_pkg::OP_TRNG_CLEAR:   trng_clr_o = access;
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed_q  <= 1'b0;
			unlock_q <= 1'b0;
			own_q    <= '0;
		end else begin
			unlock_q <= unlock_i;
			if (unlock_start_o) begin
				armed_q <= 1'b0; // a failed check needs a new OP_UNLOCK
			end else if (arm_op) begin
				armed_q <= 1'b1;
			end
			if (stat_clr) begin
				own_q.raw[rot_regs_pkg::CLEARABLE_MSB:0] <= '0;
			end else begin
				if (unlock_rise) begin
					own_q.f.root_active <= 1'b1;
				end
				if (key_clr) begin
					own_q.f.key_loaded <= 1'b0;
				end else if (key_wr && key_idx == 2'd3) begin
					own_q.f.key_loaded <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				key_q[i] <= '0;
			end
		end else if (key_clr) begin
			for (int i = 0; i < 4; i++) begin
				key_q[i] <= '0;
			end
		end else if (key_wr) begin
			key_q[key_idx] <= wdata_i;
		end
	end

	// engine state merged into the status word
	always_comb begin
		status                  = own_q;
		status.f.check_busy     = check_busy_i;
		status.f.unlocked       = unlock_i;
		status.f.trng_valid     = rnd_valid_i;
		status.f.trng_count     = gen_count_i;
		status.f.root_active    = own_q.f.root_active | unlock_rise; // same cycle as unlocked
	end

	always_comb begin
		rd_mux = '0;
		case (addr_i)
			rot_map_pkg::ADDR_STATUS: rd_mux = status.raw;
			rot_map_pkg::ADDR_KEY0,
			rot_map_pkg::ADDR_KEY1,
			rot_map_pkg::ADDR_KEY2,
			rot_map_pkg::ADDR_KEY3: begin
				if (unlock_i) begin
					rd_mux = key_q[key_idx];
				end
			end
			rot_map_pkg::ADDR_TRNG: begin
				if (unlock_i) begin
					rd_mux = rnd_i;
				end
			end
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata_q <= '0;
		end else begin
			rdata_q <= re_i ? rd_mux : '0; // zero outside read replies
		end
	end

	assign rdata_o = rdata_q;

endmodule

//--- design/rot_top.sv
module rot_top #(
	parameter logic [31:0] UNLOCK_SEQ   = 32'hF0F0AAAA,
	parameter logic [31:0] LFSR_SEED    = 32'hACE1ACE1, // must be nonzero
	parameter int          TRNG_MAX_GEN = 6             // at most 7
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           we_i,
	input  logic                           re_i,
	input  logic [rot_map_pkg::ADDR_W-1:0] addr_i,
	input  logic [rot_map_pkg::DATA_W-1:0] wdata_i,
	output logic [rot_map_pkg::DATA_W-1:0] rdata_o
);

	logic                           unlock_start;
	logic [rot_map_pkg::DATA_W-1:0] unlock_word;
	logic                           check_busy;
	logic                           unlock;
	logic                           trng_gen;
	logic                           trng_clr;
	logic [rot_map_pkg::DATA_W-1:0] rnd;
	logic                           rnd_valid;
	logic [rot_regs_pkg::CNT_W-1:0] gen_count;

	rot_regs i_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.we_i           (we_i),
		.re_i           (re_i),
		.addr_i         (addr_i),
		.wdata_i        (wdata_i),
		.rdata_o        (rdata_o),
		.unlock_start_o (unlock_start),
		.unlock_word_o  (unlock_word),
		.check_busy_i   (check_busy),
		.unlock_i       (unlock),
		.trng_gen_o     (trng_gen),
		.trng_clr_o     (trng_clr),
		.rnd_i          (rnd),
		.rnd_valid_i    (rnd_valid),
		.gen_count_i    (gen_count)
	);

	unlock_checker #(
		.UNLOCK_SEQ (UNLOCK_SEQ)
	) i_unlock (
		.clk            (clk),
		.rst_n          (rst_n),
		.unlock_start_i (unlock_start),
		.unlock_word_i  (unlock_word),
		.check_busy_o   (check_busy),
		.unlock_o       (unlock)
	);

	trng_lfsr #(
		.LFSR_SEED    (LFSR_SEED),
		.TRNG_MAX_GEN (TRNG_MAX_GEN)
	) i_trng (
		.clk         (clk),
		.rst_n       (rst_n),
		.gen_i       (trng_gen),
		.clr_i       (trng_clr),
		.rnd_o       (rnd),
		.rnd_valid_o (rnd_valid),
		.gen_count_o (gen_count)
	);

endmodule

//--- verif/rot_assert.sv
module rot_assert #(
	parameter logic [31:0] UNLOCK_SEQ   = 32'hF0F0AAAA,
	parameter int          TRNG_MAX_GEN = 6
) (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           we_i,
	input logic                           re_i,
	input logic [rot_map_pkg::ADDR_W-1:0] addr_i,
	input logic [rot_map_pkg::DATA_W-1:0] wdata_i,
	input logic [rot_map_pkg::DATA_W-1:0] rdata_o
);

	timeunit 1ns;
	timeprecision 1ps;

	logic                           armed_m;
	logic                           busy_m;
	logic [4:0]                     busy_cnt;
	logic                           match_m;
	logic                           unlocked_m;
	logic                           root_m;
	logic                           key_loaded_m;
	logic                           valid_m;
	logic [rot_regs_pkg::CNT_W-1:0] gen_m;
	logic [31:0]                    key_m [4]; // shadow of the last written key words
	logic                           op_wr;
	logic                           key_addr;
	logic                           access;
	logic [31:0]                    exp_rd;
	logic                           rd_pend;
	logic                           rd_rnd;
	logic                           exp_nz;
	logic [31:0]                    exp_q;
	logic                           err_idle;
	logic                           err_data;
	logic                           err_rnd;
	logic                           err_any;

	initial begin
		err_idle = 1'b0;
		err_data = 1'b0;
		err_rnd  = 1'b0;
	end

	assign op_wr    = we_i && (addr_i == rot_map_pkg::ADDR_OP);
	assign key_addr = addr_i inside {rot_map_pkg::ADDR_KEY0, rot_map_pkg::ADDR_KEY1,
		rot_map_pkg::ADDR_KEY2, rot_map_pkg::ADDR_KEY3};
	assign access   = unlocked_m && !busy_m;
	assign err_any  = err_idle | err_data | err_rnd;

	// expected reply, the random word is checked apart
	always_comb begin
		exp_rd = '0;
		if (addr_i == rot_map_pkg::ADDR_STATUS) begin
			exp_rd = {busy_m, unlocked_m, valid_m, gen_m, 20'd0, key_loaded_m, 4'd0, root_m};
		end else if (key_addr && unlocked_m) begin
			exp_rd = key_m[addr_i[3:2]];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed_m      <= 1'b0;
			busy_m       <= 1'b0;
			busy_cnt     <= '0;
			match_m      <= 1'b0;
			unlocked_m   <= 1'b0;
			root_m       <= 1'b0;
			key_loaded_m <= 1'b0;
			valid_m      <= 1'b0;
			gen_m        <= '0;
			key_m        <= '{default: '0};
			rd_pend      <= 1'b0;
			rd_rnd       <= 1'b0;
			exp_nz       <= 1'b0;
			exp_q        <= '0;
		end else begin
			rd_pend <= re_i;
			rd_rnd  <= re_i && (addr_i == rot_map_pkg::ADDR_TRNG);
			exp_nz  <= unlocked_m && valid_m;
			exp_q   <= exp_rd;
			if (busy_m) begin
				busy_cnt <= busy_cnt - 5'd1;
				if (busy_cnt == 5'd0) begin
					busy_m     <= 1'b0;
					unlocked_m <= match_m; // a check only runs while locked
					root_m     <= match_m;
				end
			end else if (we_i && addr_i == rot_map_pkg::ADDR_UNLOCK && armed_m && !unlocked_m) begin
				armed_m  <= 1'b0;
				busy_m   <= 1'b1;
				busy_cnt <= 5'd31; // 32 busy cycles
				match_m  <= (wdata_i == UNLOCK_SEQ);
			end else if (op_wr && wdata_i[7:0] == rot_map_pkg::OP_UNLOCK && !unlocked_m) begin
				armed_m <= 1'b1;
			end
			if (access && we_i && key_addr) begin
				key_m[addr_i[3:2]] <= wdata_i;
				key_loaded_m       <= key_loaded_m | (addr_i == rot_map_pkg::ADDR_KEY3);
			end
			if (access && op_wr) begin
				case (wdata_i[7:0])
					rot_map_pkg::OP_STATUS_CLEAR: begin
						key_loaded_m <= 1'b0;
						root_m       <= 1'b0;
					end
					rot_map_pkg::OP_KEY_CLEAR: begin
						key_loaded_m <= 1'b0;
						key_m        <= '{default: '0};
					end
					rot_map_pkg::OP_TRNG_GEN: begin
						if (gen_m != rot_regs_pkg::CNT_W'(TRNG_MAX_GEN)) begin
							gen_m   <= gen_m + 1'b1;
							valid_m <= 1'b1;
						end
					end
					rot_map_pkg::OP_TRNG_CLEAR: valid_m <= 1'b0;
					default: begin
					end
				endcase
			end
		end
	end

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!rd_pend |-> rdata_o == '0)
		else begin
			$error("FAIL %0t: rdata_o not zero outside a read reply", $time);
			err_idle = 1'b1;
		end

	a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
		rd_pend && !rd_rnd |-> rdata_o == exp_q)
		else begin
			$error("FAIL %0t: read returned %h, expected %h", $time, rdata_o, exp_q);
			err_data = 1'b1;
		end

	a_trng_word: assert property (@(posedge clk) disable iff (!rst_n)
		rd_pend && rd_rnd |-> (rdata_o != '0) == exp_nz)
		else begin
			$error("FAIL %0t: random word %h, nonzero expected %b", $time, rdata_o, exp_nz);
			err_rnd = 1'b1;
		end

endmodule

//--- verif/rot_tb.sv
module rot_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_PERIOD      = 40;
	localparam int          RESET_CYCLES    = 10;
	localparam int          WATCHDOG_CYCLES = 400; // sequences need about 220 cycles
	localparam logic [31:0] GOOD_WORD       = 32'hF0F0AAAA; // default UNLOCK_SEQ of rot_top

	logic                           clk;
	logic                           rst_n;
	logic                           we_i;
	logic                           re_i;
	logic [rot_map_pkg::ADDR_W-1:0] addr_i;
	logic [rot_map_pkg::DATA_W-1:0] wdata_i;
	logic [rot_map_pkg::DATA_W-1:0] rdata_o;
	logic [31:0]                    rd_data;

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	rot_top i_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.we_i    (we_i),
		.re_i    (re_i),
		.addr_i  (addr_i),
		.wdata_i (wdata_i),
		.rdata_o (rdata_o)
	);

	bind rot_top rot_assert #(
		.UNLOCK_SEQ   (UNLOCK_SEQ),
		.TRNG_MAX_GEN (TRNG_MAX_GEN)
	) i_chk (
		.clk     (clk),
		.rst_n   (rst_n),
		.we_i    (we_i),
		.re_i    (re_i),
		.addr_i  (addr_i),
		.wdata_i (wdata_i),
		.rdata_o (rdata_o)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		we_i    <= 1'b1;
		addr_i  <= addr;
		wdata_i <= data;
		@(posedge clk);
		we_i    <= 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		re_i   <= 1'b1;
		addr_i <= addr;
		@(posedge clk);
		re_i   <= 1'b0;
		@(negedge clk);
		data = rdata_o; // reply is stable by now
	endtask

	task automatic run_op(input rot_map_pkg::op_e op);
		write_reg(rot_map_pkg::ADDR_OP, {24'd0, op});
	endtask

	task automatic read_keys();
		for (int i = 0; i < 4; i++) begin
			read_reg(rot_map_pkg::ADDR_KEY0 + 8'(4 * i), rd_data);
		end
	endtask

	// arm, send the word, poll status until check_busy drops
	task automatic try_unlock(input logic [31:0] word, input int skew);
		run_op(rot_map_pkg::OP_UNLOCK);
		write_reg(rot_map_pkg::ADDR_UNLOCK, word);
		repeat (skew) @(posedge clk); // shifts which edges the polls land on
		do begin
			read_reg(rot_map_pkg::ADDR_STATUS, rd_data);
		end while (rd_data[31]);
	endtask

	initial begin
		wait (i_dut.i_chk.err_any);
		stop_run($sformatf("FAIL %0t ns: a bound assertion saw a wrong read value", $time));
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_run($sformatf("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		logic [31:0] bad_word;
		void'($urandom(98104));
		rst_n   <= 1'b0;
		we_i    <= 1'b0;
		re_i    <= 1'b0;
		addr_i  <= '0;
		wdata_i <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// locked block
		read_keys();
		read_reg(rot_map_pkg::ADDR_TRNG, rd_data);
		write_reg(rot_map_pkg::ADDR_UNLOCK, GOOD_WORD); // not armed yet
		run_op(rot_map_pkg::OP_TRNG_GEN);
		read_reg(rot_map_pkg::ADDR_STATUS, rd_data);

		bad_word = $urandom();
		if (bad_word == GOOD_WORD) begin
			bad_word = ~bad_word;
		end
		try_unlock(bad_word, 0);
		read_keys();
		try_unlock(GOOD_WORD, 1); // odd poll phase, catches a late busy fall

		for (int i = 0; i < 4; i++) begin
			write_reg(rot_map_pkg::ADDR_KEY0 + 8'(4 * i), $urandom());
		end
		read_keys();
		read_reg(rot_map_pkg::ADDR_STATUS, rd_data);

		repeat (8) begin // runs past the generation cap
			run_op(rot_map_pkg::OP_TRNG_GEN);
			read_reg(rot_map_pkg::ADDR_STATUS, rd_data);
			read_reg(rot_map_pkg::ADDR_TRNG, rd_data);
		end

		run_op(rot_map_pkg::OP_TRNG_CLEAR);
		read_reg(rot_map_pkg::ADDR_TRNG, rd_data);
		read_reg(rot_map_pkg::ADDR_STATUS, rd_data);
		run_op(rot_map_pkg::OP_STATUS_CLEAR);
		read_reg(rot_map_pkg::ADDR_STATUS, rd_data);
		read_keys();
		write_reg(rot_map_pkg::ADDR_KEY3, $urandom()); // key_loaded back up before key clear
		read_reg(rot_map_pkg::ADDR_STATUS, rd_data);
		run_op(rot_map_pkg::OP_KEY_CLEAR);
		read_keys();
		read_reg(rot_map_pkg::ADDR_STATUS, rd_data);
		repeat (2) @(posedge clk);

		if (i_dut.i_chk.err_any) begin
			stop_run($sformatf("FAIL %0t ns: assertion errors were reported", $time));
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

//--- tb.f
design/rot_map_pkg.sv
design/rot_regs_pkg.sv
design/unlock_checker.sv
design/trng_lfsr.sv
design/rot_regs.sv
design/rot_top.sv
verif/rot_assert.sv
verif/rot_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rot_tb
FLIST     ?= tb.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST LOG OBJ_DIR SIM_ARGS"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "result: FAIL"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "result: no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
